/* include/array_defs.svh */
`ifndef ARRAY_DEFS_SVH
`define ARRAY_DEFS_SVH

// PE grid of the systolic array
`define ARRAY_ROWS 4
`define ARRAY_COLS 4

// Largest N for an N x N product
`define MAX_MAT_N 16

// Entries in the coordinate FIFO between gather and drain
`define COORD_FIFO_DEPTH 8

`endif

/* source/array_pkg.sv */
`default_nettype none

package array_pkg;

  `include "array_defs.svh"

  localparam int N_BITS = $clog2(`MAX_MAT_N + 1);   // Holds N itself, not only N-1
  // Worst case is the corner PE delay plus one compute window
  localparam int CT_BITS = $clog2((`ARRAY_ROWS - 1) + (`ARRAY_COLS - 1) +
                                  ((`MAX_MAT_N + 3) / 4) + 1);

  typedef logic [N_BITS-1:0]  coord_t;
  typedef logic [CT_BITS-1:0] cycle_t;

  // ceil(N/4) cycles, one per group of four MACs
  function automatic cycle_t compute_window(coord_t n);
    return cycle_t'((int'(n) + 3) / 4);
  endfunction

endpackage

`default_nettype wire

/* source/coord_if.sv */
`timescale 1ns/100ps
`default_nettype none

interface coord_if;
  import array_pkg::*;

  logic   valid;   // Item present
  logic   hold;    // Consumer not ready, producer keeps item stable
  coord_t row;
  coord_t col;

  modport producer (output valid, output row, output col, input hold);
  modport consumer (input valid, input row, input col, output hold);

endinterface

`default_nettype wire

/* source/tile_scheduler.sv */
`timescale 1ns/100ps
`default_nettype none

`include "array_defs.svh"

module tile_scheduler (
  input  logic              clk,
  input  logic              reset,
  input  logic              start,
  input  array_pkg::coord_t mat_size,
  input  logic              stall,
  output logic              input_valid,
  output array_pkg::coord_t pos_row,
  output array_pkg::coord_t pos_col,
  output logic              busy
);
  import array_pkg::*;

  coord_t size_q;      // N latched at start
  cycle_t win_cnt;     // Cycles left until the next injection
  coord_t next_row;
  coord_t next_col;
  logic   last_tile;

  assign next_col  = pos_col + coord_t'(`ARRAY_COLS);
  assign next_row  = pos_row + coord_t'(`ARRAY_ROWS);
  assign last_tile = (next_col >= size_q) && (next_row >= size_q);

  // Inject whenever the window has run out
  assign input_valid = busy && (win_cnt == '0);

  always_ff @(posedge clk) begin
    if (reset) begin
      busy    <= 1'b0;
      win_cnt <= '0;
    end else if (!busy) begin
      if (start) begin
        busy    <= 1'b1;
        win_cnt <= '0;   // First tile goes in the next cycle
        size_q  <= mat_size;
        pos_row <= '0;
        pos_col <= '0;
      end
    end else if (!stall) begin
      if (input_valid) begin
        win_cnt <= compute_window(size_q) - cycle_t'(1);
        if (last_tile) begin
          busy <= 1'b0;
        end else if (next_col < size_q) begin
          pos_col <= next_col;   // Step along the tile row
        end else begin
          pos_col <= '0;         // Wrap to the next tile row
          pos_row <= next_row;
        end
      end else begin
        win_cnt <= win_cnt - cycle_t'(1);
      end
    end
  end

endmodule

`default_nettype wire

/* source/output_coordinator.sv */
`timescale 1ns/100ps
`default_nettype none

`include "array_defs.svh"

module output_coordinator #(
  parameter int ROWS = `ARRAY_ROWS,
  parameter int COLS = `ARRAY_COLS
) (
  input  logic              clk,
  input  logic              reset,
  input  array_pkg::coord_t mat_size,
  input  logic              input_valid,   // Tile injected at PE(0,0)
  input  logic              stall,
  input  array_pkg::coord_t pos_row,       // Tile base row
  input  array_pkg::coord_t pos_col,       // Tile base column
  output logic              out_valid [ROWS*COLS],
  output array_pkg::coord_t out_row   [ROWS*COLS],
  output array_pkg::coord_t out_col   [ROWS*COLS]
);
  import array_pkg::*;

  localparam int NUM_PE = ROWS * COLS;

  cycle_t window;
  cycle_t start_cnt [NUM_PE];   // Window length the PE started with
  cycle_t cur_cnt   [NUM_PE];   // Zero in the PE's last compute cycle
  logic   active    [NUM_PE];
  coord_t base_row  [NUM_PE];
  coord_t base_col  [NUM_PE];
  logic   started   [NUM_PE];   // First active cycle
  logic   load      [NUM_PE];   // Take a tile next edge
  cycle_t ld_cnt    [NUM_PE];
  coord_t ld_row    [NUM_PE];
  coord_t ld_col    [NUM_PE];

  function automatic int pe_idx(int r, int c);
    return r * COLS + c;
  endfunction

  // Column 0 is fed from above, every other PE from its left
  function automatic int src_idx(int r, int c);
    return (c == 0) ? pe_idx(r - 1, 0) : pe_idx(r, c - 1);
  endfunction

  assign window = compute_window(mat_size);

  always_comb begin
    for (int k = 0; k < NUM_PE; k++) begin
      started[k] = active[k] && (cur_cnt[k] == start_cnt[k] - cycle_t'(1));
    end
    load[0]   = input_valid;
    ld_cnt[0] = window;
    ld_row[0] = pos_row;
    ld_col[0] = pos_col;
    for (int i = 0; i < ROWS; i++) begin
      for (int j = 0; j < COLS; j++) begin
        if (i + j != 0) begin
          load[pe_idx(i, j)]   = started[src_idx(i, j)];
          ld_cnt[pe_idx(i, j)] = start_cnt[src_idx(i, j)];
          ld_row[pe_idx(i, j)] = base_row[src_idx(i, j)];
          ld_col[pe_idx(i, j)] = base_col[src_idx(i, j)];
        end
      end
    end
  end

  always_ff @(posedge clk) begin
    if (reset) begin
      for (int k = 0; k < NUM_PE; k++) begin
        active[k] <= 1'b0;
      end
    end else if (!stall) begin
      for (int k = 0; k < NUM_PE; k++) begin
        if (load[k]) begin
          active[k] <= 1'b1;   // New tile wins over retiring the old one
        end else if (active[k] && cur_cnt[k] == '0) begin
          active[k] <= 1'b0;
        end
      end
    end
  end

  always_ff @(posedge clk) begin
    if (!stall) begin
      for (int k = 0; k < NUM_PE; k++) begin
        if (load[k]) begin
          start_cnt[k] <= ld_cnt[k];
          cur_cnt[k]   <= ld_cnt[k] - cycle_t'(1);
          base_row[k]  <= ld_row[k];
          base_col[k]  <= ld_col[k];
        end else if (active[k] && cur_cnt[k] != '0) begin
          cur_cnt[k] <= cur_cnt[k] - cycle_t'(1);
        end
      end
    end
  end

  // Absolute result position is tile base plus PE offset
  always_comb begin
    for (int i = 0; i < ROWS; i++) begin
      for (int j = 0; j < COLS; j++) begin
        out_valid[pe_idx(i, j)] = active[pe_idx(i, j)] && (cur_cnt[pe_idx(i, j)] == '0) &&
                                  !stall;
        out_row[pe_idx(i, j)] = base_row[pe_idx(i, j)] + coord_t'(i);
        out_col[pe_idx(i, j)] = base_col[pe_idx(i, j)] + coord_t'(j);
      end
    end
  end

endmodule

`default_nettype wire

/* source/result_gather.sv */
`timescale 1ns/100ps
`default_nettype none

`include "array_defs.svh"

module result_gather #(
  parameter int ROWS = `ARRAY_ROWS,
  parameter int COLS = `ARRAY_COLS
) (
  input  logic              clk,
  input  logic              reset,
  input  logic              out_valid [ROWS*COLS],
  input  array_pkg::coord_t out_row   [ROWS*COLS],
  input  array_pkg::coord_t out_col   [ROWS*COLS],
  output logic              stall,
  coord_if.producer         gather_q
);
  import array_pkg::*;

  localparam int NUM_PE   = ROWS * COLS;
  localparam int IDX_BITS = (NUM_PE > 1) ? $clog2(NUM_PE) : 1;

  logic [NUM_PE-1:0]   pending;            // Flags captured but not yet pushed
  coord_t              pend_row [NUM_PE];
  coord_t              pend_col [NUM_PE];
  logic [IDX_BITS-1:0] sel;                // Lowest pending index
  logic                found;

  always_comb begin
    sel   = '0;
    found = 1'b0;
    for (int k = 0; k < NUM_PE; k++) begin
      if (pending[k] && !found) begin
        sel   = IDX_BITS'(k);
        found = 1'b1;
      end
    end
  end

  assign stall          = (|pending) || gather_q.hold;
  assign gather_q.valid = found;
  assign gather_q.row   = pend_row[sel];
  assign gather_q.col   = pend_col[sel];

  always_ff @(posedge clk) begin
    if (reset) begin
      pending <= '0;
    end else if (!stall) begin
      for (int k = 0; k < NUM_PE; k++) begin
        pending[k] <= out_valid[k];   // Empty set, take a new vector
      end
    end else if (gather_q.valid && !gather_q.hold) begin
      pending[sel] <= 1'b0;
    end
  end

  always_ff @(posedge clk) begin
    if (!stall) begin
      for (int k = 0; k < NUM_PE; k++) begin
        pend_row[k] <= out_row[k];
        pend_col[k] <= out_col[k];
      end
    end
  end

endmodule

`default_nettype wire

/* source/coord_fifo.sv */
`timescale 1ns/100ps
`default_nettype none

`include "array_defs.svh"

module coord_fifo #(
  parameter int DEPTH = `COORD_FIFO_DEPTH
) (
  input  logic       clk,
  input  logic       reset,
  coord_if.consumer  in_q,
  coord_if.producer  out_q
);
  import array_pkg::*;

  localparam int PTR_BITS = (DEPTH > 1) ? $clog2(DEPTH) : 1;
  localparam int CNT_BITS = $clog2(DEPTH + 1);

  coord_t              mem_row [DEPTH];
  coord_t              mem_col [DEPTH];
  logic [PTR_BITS-1:0] wr_ptr;
  logic [PTR_BITS-1:0] rd_ptr;
  logic [CNT_BITS-1:0] count;
  logic                push;
  logic                pop;

  // Wraps for depths that are not a power of two
  function automatic logic [PTR_BITS-1:0] ptr_next(logic [PTR_BITS-1:0] p);
    return (p == PTR_BITS'(DEPTH - 1)) ? '0 : p + 1'b1;
  endfunction

  assign in_q.hold   = (count == CNT_BITS'(DEPTH));   // Full
  assign out_q.valid = (count != '0);
  assign out_q.row   = mem_row[rd_ptr];
  assign out_q.col   = mem_col[rd_ptr];

  assign push = in_q.valid && !in_q.hold;
  assign pop  = out_q.valid && !out_q.hold;

  always_ff @(posedge clk) begin
    if (reset) begin
      wr_ptr <= '0;
      rd_ptr <= '0;
      count  <= '0;
    end else begin
      if (push) wr_ptr <= ptr_next(wr_ptr);
      if (pop) rd_ptr <= ptr_next(rd_ptr);
      if (push && !pop) begin
        count <= count + 1'b1;
      end else if (pop && !push) begin
        count <= count - 1'b1;
      end
    end
  end

  always_ff @(posedge clk) begin
    if (push) begin
      mem_row[wr_ptr] <= in_q.row;
      mem_col[wr_ptr] <= in_q.col;
    end
  end

endmodule

`default_nettype wire

/* source/result_drain.sv */
`timescale 1ns/100ps
`default_nettype none

module result_drain (
  input  logic              clk,
  input  logic              reset,
  input  logic              start,
  input  array_pkg::coord_t mat_size,
  coord_if.consumer         drain_q,
  input  logic              result_hold,
  output logic              result_valid,
  output array_pkg::coord_t result_row,
  output array_pkg::coord_t result_col,
  output logic              done
);
  import array_pkg::*;

  localparam int CNT_BITS = 2 * N_BITS;   // Room for N squared

  coord_t              size_q;
  logic [CNT_BITS-1:0] res_cnt;
  logic [CNT_BITS-1:0] total;
  logic                in_range;
  logic                out_free;    // Output register empty or emptying
  logic                accept;

  assign total    = CNT_BITS'(size_q) * CNT_BITS'(size_q);
  assign in_range = (drain_q.row < size_q) && (drain_q.col < size_q);
  assign out_free = !result_valid || !result_hold;

  // Out-of-range items never wait
  assign drain_q.hold = in_range && !out_free;
  assign accept       = drain_q.valid && in_range && out_free;

  always_ff @(posedge clk) begin
    if (reset) begin
      result_valid <= 1'b0;
      done         <= 1'b0;
      res_cnt      <= '0;
      size_q       <= '0;
    end else begin
      if (start) begin
        done    <= 1'b0;
        res_cnt <= '0;
        size_q  <= mat_size;
      end else if (result_valid && !result_hold) begin
        res_cnt <= res_cnt + 1'b1;
        if (res_cnt + 1'b1 == total) done <= 1'b1;   // Last of N*N leaves
      end
      if (out_free) result_valid <= accept;
    end
  end

  always_ff @(posedge clk) begin
    if (accept) begin
      result_row <= drain_q.row;
      result_col <= drain_q.col;
    end
  end

endmodule

`default_nettype wire

/* source/matmul_tracker_top.sv */
`timescale 1ns/100ps
`default_nettype none

`include "array_defs.svh"

module matmul_tracker_top (
  input  logic              clk,
  input  logic              reset,
  input  logic              start,
  input  array_pkg::coord_t mat_size,
  input  logic              result_hold,
  output logic              busy,
  output logic              result_valid,
  output array_pkg::coord_t result_row,
  output array_pkg::coord_t result_col,
  output logic              done
);
  import array_pkg::*;

  localparam int NUM_PE = `ARRAY_ROWS * `ARRAY_COLS;

  logic   input_valid;
  coord_t pos_row;
  coord_t pos_col;
  logic   stall;          // Back-pressure from the gather stage
  logic   out_valid [NUM_PE];
  coord_t out_row   [NUM_PE];
  coord_t out_col   [NUM_PE];

  coord_if gather_q ();
  coord_if drain_q ();

  tile_scheduler u_tile_scheduler (
    .clk(clk), .reset(reset), .start(start), .mat_size(mat_size), .stall(stall),
    .input_valid(input_valid), .pos_row(pos_row), .pos_col(pos_col), .busy(busy)
  );

  output_coordinator #(.ROWS(`ARRAY_ROWS), .COLS(`ARRAY_COLS)) u_output_coordinator (
    .clk(clk), .reset(reset), .mat_size(mat_size), .input_valid(input_valid),
    .stall(stall), .pos_row(pos_row), .pos_col(pos_col),
    .out_valid(out_valid), .out_row(out_row), .out_col(out_col)
  );

  result_gather #(.ROWS(`ARRAY_ROWS), .COLS(`ARRAY_COLS)) u_result_gather (
    .clk(clk), .reset(reset), .out_valid(out_valid), .out_row(out_row),
    .out_col(out_col), .stall(stall), .gather_q(gather_q)
  );

  coord_fifo #(.DEPTH(`COORD_FIFO_DEPTH)) u_coord_fifo (
    .clk(clk), .reset(reset), .in_q(gather_q), .out_q(drain_q)
  );

  result_drain u_result_drain (
    .clk(clk), .reset(reset), .start(start), .mat_size(mat_size), .drain_q(drain_q),
    .result_hold(result_hold), .result_valid(result_valid), .result_row(result_row),
    .result_col(result_col), .done(done)
  );

endmodule

`default_nettype wire

/* bench/tb_matmul_tracker.sv */
`timescale 1ns/100ps
`default_nettype none

`include "array_defs.svh"

module tb_matmul_tracker;
  import array_pkg::*;

  localparam int NUM_CASES     = 6;
  localparam int SETTLE_CYCLES = 64;   // Lets out-of-range leftovers flush between runs
  localparam int ARRAY_DEPTH   = `ARRAY_ROWS + `ARRAY_COLS - 1;

  // Matrix size and result_hold density in percent, one row per run
  int case_n    [NUM_CASES] = '{3, 4, 5, 8, 13, 16};
  int case_hold [NUM_CASES] = '{0, 25, 50, 12, 37, 50};

  logic   clk = 1'b0;
  logic   reset;
  logic   start;
  coord_t mat_size;
  logic   result_hold;
  logic   busy;
  logic   result_valid;
  coord_t result_row;
  coord_t result_col;
  logic   done;

  logic [31:0] lcg_state;
  int          cycle_cnt = 0;
  int          run_n = 0;        // N of the run in progress
  int          accepted = 0;     // Results taken at the top ports this run
  int          seen_total;
  logic        seen [`MAX_MAT_N][`MAX_MAT_N];
  logic        prev_valid;
  logic        prev_hold;
  logic        prev_done;
  coord_t      prev_row;
  coord_t      prev_col;

  matmul_tracker_top u_matmul_tracker_top (
    .clk(clk), .reset(reset), .start(start), .mat_size(mat_size),
    .result_hold(result_hold), .busy(busy), .result_valid(result_valid),
    .result_row(result_row), .result_col(result_col), .done(done)
  );

  always #2 clk = ~clk;   // 4 ns period

  task automatic check_equal(input int actual, input int expected, input string what);
    if (actual != expected) begin
      $display("** Error @ %0t ns: %s (got %0d, expected %0d)", $time, what, actual, expected);
      $display("Simulation finished: FAIL");
      $fatal(1, "mismatch");
    end
  endtask

  function automatic logic [31:0] lcg_next(logic [31:0] s);
    return s * 32'd1664525 + 32'd1013904223;
  endfunction

  // Tiles times (array depth + window) times 4, summed over all runs
  function automatic int cycle_limit();
    int total;
    int win;
    int tiles;
    total = 100;   // Reset and idle checks
    for (int t = 0; t < NUM_CASES; t++) begin
      win   = (case_n[t] + 3) / 4;
      tiles = ((case_n[t] + `ARRAY_ROWS - 1) / `ARRAY_ROWS) *
              ((case_n[t] + `ARRAY_COLS - 1) / `ARRAY_COLS);
      total += tiles * (ARRAY_DEPTH + win) * 4 + SETTLE_CYCLES;
    end
    return total;
  endfunction

  always @(posedge clk) begin
    cycle_cnt <= cycle_cnt + 1;
    if (cycle_cnt >= cycle_limit()) begin
      $display("Timeout: the runs did not finish within %0d cycles", cycle_cnt);
      $display("Simulation finished: FAIL");
      $fatal(1, "timeout");
    end
  end

  // Port monitor, reads the values that were stable before this edge
  always @(posedge clk) begin
    if (reset) begin
      prev_valid = 1'b0;
      prev_hold  = 1'b0;
      prev_done  = 1'b0;
    end else begin
      if (start) begin
        run_n    = int'(mat_size);
        accepted = 0;
        foreach (seen[r, c]) seen[r][c] = 1'b0;
      end
      if (prev_valid && prev_hold) begin   // Output must not move under hold
        check_equal(result_valid, 1, "result_valid dropped while held");
        check_equal(result_row, prev_row, "result_row changed while held");
        check_equal(result_col, prev_col, "result_col changed while held");
      end
      if (done) check_equal(result_valid, 0, "result_valid after done");
      if (done && !prev_done) check_equal(accepted, run_n * run_n, "results before done");
      if (result_valid && !result_hold) begin
        check_equal(int'(result_row) < run_n, 1, "result row below N");
        check_equal(int'(result_col) < run_n, 1, "result column below N");
        check_equal(seen[result_row][result_col], 0, "coordinate accepted twice");
        seen[result_row][result_col] = 1'b1;
        accepted++;
      end
      prev_valid = result_valid;
      prev_hold  = result_hold;
      prev_done  = done;
      prev_row   = result_row;
      prev_col   = result_col;
    end
  end

  initial begin
    reset       = 1'b1;
    start       = 1'b0;
    mat_size    = '0;
    result_hold = 1'b0;
    lcg_state   = 32'h6eee_e127;
    repeat (3) @(posedge clk);
    reset <= 1'b0;
    repeat (4) begin   // Idle after reset
      @(posedge clk);
      check_equal(busy, 0, "busy before start");
      check_equal(result_valid, 0, "result_valid before start");
      check_equal(done, 0, "done before start");
    end
    for (int t = 0; t < NUM_CASES; t++) begin
      @(posedge clk);
      start    <= 1'b1;
      mat_size <= coord_t'(case_n[t]);
      @(posedge clk);
      start <= 1'b0;
      @(posedge clk);
      check_equal(busy, 1, "busy after start");
      do begin
        @(posedge clk);
        lcg_state = lcg_next(lcg_state);
        result_hold <= ((lcg_state >> 16) % 100) < case_hold[t];
      end while (!done);
      result_hold <= 1'b0;
      seen_total = 0;
      foreach (seen[r, c]) seen_total += seen[r][c];
      check_equal(seen_total, case_n[t] * case_n[t], "distinct coordinates seen");
      repeat (SETTLE_CYCLES) @(posedge clk);
      check_equal(busy, 0, "busy after done");
    end
    $display("Simulation finished: PASS");
    $finish;
  end

endmodule

`default_nettype wire

/* sources.f */
+incdir+include
source/array_pkg.sv
source/coord_if.sv
source/tile_scheduler.sv
source/output_coordinator.sv
source/result_gather.sv
source/coord_fifo.sv
source/result_drain.sv
source/matmul_tracker_top.sv
bench/tb_matmul_tracker.sv

/* Bender.yml */
package:
  name: matmul_tracker

sources:
  - include_dirs:
      - include
    files:
      - source/array_pkg.sv
      - source/coord_if.sv
      - source/tile_scheduler.sv
      - source/output_coordinator.sv
      - source/result_gather.sv
      - source/coord_fifo.sv
      - source/result_drain.sv
      - source/matmul_tracker_top.sv
  - target: simulation
    include_dirs:
      - include
    files:
      - bench/tb_matmul_tracker.sv
